// ==== verilog/em_defs.svh ====
`ifndef EM_DEFS_SVH
`define EM_DEFS_SVH

`define EM_BUF_PTR_NBITS     4 // sixteen buffers in the pool.
`define EM_PORT_ID_NBITS     3 // eight destination ports.
`define EM_READ_COUNT_NBITS  4 // up to fifteen readers per buffer.

// Zero-count buffers wait here until the counter pipeline has a free slot.
`define EM_ZERO_FIFO_DEPTH   2

`endif

// ==== verilog/em_pkg.sv ====
package em_pkg;

    `include "em_defs.svh"

    typedef logic [`EM_BUF_PTR_NBITS-1:0]    buf_ptr_t;  // index of a packet buffer.
    typedef logic [`EM_PORT_ID_NBITS-1:0]    port_id_t;  // destination port of a packet.
    typedef logic [`EM_READ_COUNT_NBITS-1:0] read_cnt_t; // number of readers of a buffer.

    // The free list fills itself once after reset, then serves requests.
    typedef enum logic {
        fl_init,
        fl_run
    } fl_state_e;

endpackage

// ==== verilog/em_ram_1r1w.sv ====
`timescale 1ns/1ns

module em_ram_1r1w #(
    parameter int DATA_W = 4,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              wr,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0] din,
    input  logic [ADDR_W-1:0] raddr,
    output logic [DATA_W-1:0] dout
);

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

    // A read of the address being written returns the old contents.
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr]; // one cycle of read latency.
    end

endmodule

// ==== verilog/em_sync_fifo.sv ====
`timescale 1ns/1ns

module em_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr,
    input  logic [WIDTH-1:0] din,
    input  logic             rd,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr && !full;  // a write into a full queue is dropped.
    assign do_rd = rd && !empty;
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign dout  = mem[rd_ptr];  // head entry is visible without a read.

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/em_buf_release.sv ====
`timescale 1ns/1ns

`include "em_defs.svh"

module em_buf_release (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               init_read_count_valid,
    input  em_pkg::buf_ptr_t   init_read_count_ptr,
    input  logic               read_count_valid,
    input  em_pkg::port_id_t   read_count_port_id,
    input  em_pkg::buf_ptr_t   read_count_buf_ptr,
    input  em_pkg::read_cnt_t  read_count,
    input  logic               em_rel_buf_valid,
    input  em_pkg::buf_ptr_t   em_rel_buf_ptr,
    output logic               rel_buf_valid,
    output em_pkg::buf_ptr_t   rel_buf_ptr
);

    import em_pkg::*;

    localparam int QW = `EM_BUF_PTR_NBITS + `EM_PORT_ID_NBITS;

    logic            init_valid_d1;
    buf_ptr_t        init_ptr_d1;
    logic            rc_valid_d1;
    port_id_t        rc_port_id_d1;
    buf_ptr_t        rc_buf_ptr_d1;
    read_cnt_t       rc_d1;
    read_cnt_t       rc_set;
    logic            rel_req;
    buf_ptr_t        rel_req_ptr;
    logic            rel_req_d1;
    logic            rel_req_d2;
    logic            rel_req_d3;
    buf_ptr_t        ctr_raddr;
    buf_ptr_t        ctr_raddr_d1;
    buf_ptr_t        ctr_waddr_p1;
    buf_ptr_t        ctr_waddr_next;
    buf_ptr_t        ctr_waddr;
    buf_ptr_t        ctr_waddr_d1;
    logic            ctr_wr_next;
    logic            ctr_wr;
    logic            ctr_wr_d1;
    read_cnt_t       ctr_wdata_next;
    read_cnt_t       ctr_wdata;
    read_cnt_t       ctr_wdata_d1;
    read_cnt_t       rd_cnt;
    read_cnt_t       rd_cnt_d1;
    read_cnt_t       ctr_rdata;
    read_cnt_t       ctr_rdata_d1;
    logic [2:0]      snoop_hit_p1;
    logic            snoop_hit0;
    logic            snoop_hit12;
    read_cnt_t       snoop_wdata;
    read_cnt_t       ctr_cur;
    logic            last_reader;
    logic            zero_fifo_wr;
    logic            zero_fifo_rd;
    logic            zero_fifo_empty;
    logic            zero_fifo_full;
    logic [QW-1:0]   zero_fifo_din;
    logic [QW-1:0]   zero_fifo_dout;

    // The stored count is one less than the readers, so a single reader matches zero.
    assign rc_set = (rc_d1 == '0) ? '0 : rc_d1 - 1'b1;

    assign zero_fifo_wr  = rc_valid_d1 && (rc_d1 == '0);
    assign zero_fifo_din = {rc_buf_ptr_d1, rc_port_id_d1};
    assign zero_fifo_rd  = !zero_fifo_empty && !em_rel_buf_valid; // direct release wins.

    assign rel_req     = em_rel_buf_valid || !zero_fifo_empty;
    assign rel_req_ptr = em_rel_buf_valid ? em_rel_buf_ptr : zero_fifo_dout[QW-1 -: `EM_BUF_PTR_NBITS];

    // The RAM has no bypass, so the three writes after the read are checked here.
    assign ctr_wr_next    = rel_req_d3 || init_valid_d1;
    assign ctr_waddr_next = init_valid_d1 ? init_ptr_d1 : ctr_waddr_p1;
    assign snoop_hit_p1[2] = ctr_wr_d1 && (ctr_raddr_d1 == ctr_waddr_d1);
    assign snoop_hit_p1[1] = ctr_wr && (ctr_raddr_d1 == ctr_waddr);
    assign snoop_hit_p1[0] = ctr_wr_next && (ctr_raddr_d1 == ctr_waddr_next);

    assign ctr_cur = snoop_hit0 ? ctr_wdata : (snoop_hit12 ? snoop_wdata : ctr_rdata_d1);
    assign last_reader = (rd_cnt_d1 == ctr_cur);

    // An allocation clears the counter and takes priority over a release write.
    assign ctr_wdata_next = (init_valid_d1 || last_reader) ? '0 : ctr_cur + 1'b1;

    always_ff @(posedge clk) begin
        init_ptr_d1   <= init_read_count_ptr;
        rc_port_id_d1 <= read_count_port_id;
        rc_buf_ptr_d1 <= read_count_buf_ptr;
        rc_d1         <= read_count;
        ctr_raddr     <= rel_req_ptr;
        ctr_raddr_d1  <= ctr_raddr;
        ctr_waddr_p1  <= ctr_raddr_d1;
        ctr_waddr     <= ctr_waddr_next;
        ctr_waddr_d1  <= ctr_waddr;
        ctr_wdata     <= ctr_wdata_next;
        ctr_wdata_d1  <= ctr_wdata;
        rd_cnt_d1     <= rd_cnt;
        ctr_rdata_d1  <= ctr_rdata;
        snoop_hit0    <= snoop_hit_p1[0];
        snoop_hit12   <= |snoop_hit_p1[2:1];
        snoop_wdata   <= snoop_hit_p1[1] ? ctr_wdata : ctr_wdata_d1; // newer write first.
        rel_buf_ptr   <= ctr_waddr_p1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_valid_d1 <= 1'b0;
            rc_valid_d1   <= 1'b0;
            rel_req_d1    <= 1'b0;
            rel_req_d2    <= 1'b0;
            rel_req_d3    <= 1'b0;
            ctr_wr        <= 1'b0;
            ctr_wr_d1     <= 1'b0;
            rel_buf_valid <= 1'b0;
        end else begin
            init_valid_d1 <= init_read_count_valid;
            rc_valid_d1   <= read_count_valid;
            rel_req_d1    <= rel_req;
            rel_req_d2    <= rel_req_d1;
            rel_req_d3    <= rel_req_d2;
            ctr_wr        <= ctr_wr_next;
            ctr_wr_d1     <= ctr_wr;
            rel_buf_valid <= rel_req_d3 && last_reader;
        end
    end

    em_sync_fifo #(
        .WIDTH (QW),
        .DEPTH (`EM_ZERO_FIFO_DEPTH)
    ) zero_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (zero_fifo_wr),
        .din   (zero_fifo_din),
        .rd    (zero_fifo_rd),
        .dout  (zero_fifo_dout),
        .empty (zero_fifo_empty),
        .full  (zero_fifo_full)
    );

    em_ram_1r1w #(
        .DATA_W (`EM_READ_COUNT_NBITS),
        .ADDR_W (`EM_BUF_PTR_NBITS)
    ) read_cnt_ram_i (
        .clk   (clk),
        .wr    (rc_valid_d1),
        .waddr (rc_buf_ptr_d1),
        .din   (rc_set),
        .raddr (ctr_raddr),
        .dout  (rd_cnt)
    );

    em_ram_1r1w #(
        .DATA_W (`EM_READ_COUNT_NBITS),
        .ADDR_W (`EM_BUF_PTR_NBITS)
    ) rel_ctr_ram_i (
        .clk   (clk),
        .wr    (ctr_wr),
        .waddr (ctr_waddr),
        .din   (ctr_wdata),
        .raddr (ctr_raddr),
        .dout  (ctr_rdata)
    );

endmodule

// ==== verilog/em_free_list.sv ====
`timescale 1ns/1ns

`include "em_defs.svh"

module em_free_list (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        alloc_req,
    output logic                        alloc_valid,
    output em_pkg::buf_ptr_t            alloc_ptr,
    input  logic                        ret_valid,
    input  em_pkg::buf_ptr_t            ret_ptr,
    output logic [`EM_BUF_PTR_NBITS:0]  free_count,
    output logic                        init_done
);

    import em_pkg::*;

    fl_state_e state;
    buf_ptr_t  init_ptr;
    buf_ptr_t  stack [0:(1 << `EM_BUF_PTR_NBITS)-1];
    buf_ptr_t  top_idx;
    buf_ptr_t  push_idx;
    logic      pop;

    assign top_idx   = free_count[`EM_BUF_PTR_NBITS-1:0] - 1'b1;
    assign push_idx  = free_count[`EM_BUF_PTR_NBITS-1:0];
    assign pop       = alloc_req && (state == fl_run) && (free_count != '0);
    assign init_done = (state == fl_run);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= fl_init;
            init_ptr    <= '0;
            free_count  <= '0;
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= pop;
            if (state == fl_init) begin
                init_ptr   <= init_ptr + 1'b1;
                free_count <= free_count + 1'b1;
                if (init_ptr == '1) begin
                    state <= fl_run; // every pointer is on the stack.
                end
            end else if (pop && !ret_valid) begin
                free_count <= free_count - 1'b1;
            end else if (ret_valid && !pop) begin
                free_count <= free_count + 1'b1;
            end
        end
    end

    // The last pointer pushed is the first one handed out.
    always_ff @(posedge clk) begin
        if (state == fl_init) begin
            stack[push_idx] <= init_ptr;
        end else if (ret_valid && !pop) begin
            stack[push_idx] <= ret_ptr;
        end
        if (pop) begin
            alloc_ptr <= ret_valid ? ret_ptr : stack[top_idx]; // a returning pointer goes straight out.
        end
    end

endmodule

// ==== verilog/em_buf_mgr.sv ====
`timescale 1ns/1ns

`include "em_defs.svh"

module em_buf_mgr (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        alloc_req,
    output logic                        alloc_valid,
    output em_pkg::buf_ptr_t            alloc_ptr,
    input  logic                        read_count_valid,
    input  em_pkg::port_id_t            read_count_port_id,
    input  em_pkg::buf_ptr_t            read_count_buf_ptr,
    input  em_pkg::read_cnt_t           read_count,
    input  logic                        em_rel_buf_valid,
    input  em_pkg::buf_ptr_t            em_rel_buf_ptr,
    output logic                        rel_buf_valid,
    output em_pkg::buf_ptr_t            rel_buf_ptr,
    output logic [`EM_BUF_PTR_NBITS:0]  free_count,
    output logic                        init_done
);

    import em_pkg::*;

    logic     alloc_valid_w;
    buf_ptr_t alloc_ptr_w;
    logic     rel_valid_w;
    buf_ptr_t rel_ptr_w;

    assign alloc_valid   = alloc_valid_w;
    assign alloc_ptr     = alloc_ptr_w;
    assign rel_buf_valid = rel_valid_w;
    assign rel_buf_ptr   = rel_ptr_w;

    em_free_list free_list_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_req   (alloc_req),
        .alloc_valid (alloc_valid_w),
        .alloc_ptr   (alloc_ptr_w),
        .ret_valid   (rel_valid_w),   // freed buffers go back on the stack.
        .ret_ptr     (rel_ptr_w),
        .free_count  (free_count),
        .init_done   (init_done)
    );

    em_buf_release buf_release_i (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .init_read_count_valid (alloc_valid_w), // each allocation clears the counter.
        .init_read_count_ptr   (alloc_ptr_w),
        .read_count_valid      (read_count_valid),
        .read_count_port_id    (read_count_port_id),
        .read_count_buf_ptr    (read_count_buf_ptr),
        .read_count            (read_count),
        .em_rel_buf_valid      (em_rel_buf_valid),
        .em_rel_buf_ptr        (em_rel_buf_ptr),
        .rel_buf_valid         (rel_valid_w),
        .rel_buf_ptr           (rel_ptr_w)
    );

endmodule

// ==== verif/em_buf_mgr_sva.sv ====
`timescale 1ns/1ns

module em_buf_mgr_sva (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             zero_fifo_wr,
    input  logic             zero_fifo_full,
    input  logic             rel_buf_valid,
    input  em_pkg::buf_ptr_t rel_buf_ptr,
    input  logic             init_valid,
    input  em_pkg::buf_ptr_t init_ptr
);

    int unsigned fail_count = 0;  // read by the testbench at the end.

    // A write into a full queue would lose a zero-count buffer.
    queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(zero_fifo_wr && zero_fifo_full))
    else begin
        $error("zero-count queue written while full");
        fail_count++;
    end

    no_double_release: assert property (@(posedge clk) disable iff (!rst_n)
        rel_buf_valid |=> !(rel_buf_valid && (rel_buf_ptr == $past(rel_buf_ptr))))
    else begin
        $error("buffer %h freed in two consecutive cycles", rel_buf_ptr);
        fail_count++;
    end

    no_release_on_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        !(rel_buf_valid && init_valid && (rel_buf_ptr == init_ptr)))
    else begin
        $error("buffer %h freed while it is being allocated", rel_buf_ptr);
        fail_count++;
    end

endmodule

bind em_buf_release em_buf_mgr_sva sva_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .zero_fifo_wr   (zero_fifo_wr),
    .zero_fifo_full (zero_fifo_full),
    .rel_buf_valid  (rel_buf_valid),
    .rel_buf_ptr    (rel_buf_ptr),
    .init_valid     (init_read_count_valid),
    .init_ptr       (init_read_count_ptr)
);

// ==== verif/em_buf_mgr_tb.sv ====
`timescale 1ns/1ns

`include "em_defs.svh"

module em_buf_mgr_tb;

    import em_pkg::*;

    localparam int NBUF = 1 << `EM_BUF_PTR_NBITS;
    // cycle budget of the six tests in order, plus reset.
    localparam int TEST_CYCLES = 2 + 30 + 70 + 60 + 40 + 70 + 100;
    localparam int TIMEOUT_NS  = TEST_CYCLES * 20 + 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       alloc_req;
    logic                       alloc_valid;
    buf_ptr_t                   alloc_ptr;
    logic                       read_count_valid;
    port_id_t                   read_count_port_id;
    buf_ptr_t                   read_count_buf_ptr;
    read_cnt_t                  read_count;
    logic                       em_rel_buf_valid;
    buf_ptr_t                   em_rel_buf_ptr;
    logic                       rel_buf_valid;
    buf_ptr_t                   rel_buf_ptr;
    logic [`EM_BUF_PTR_NBITS:0] free_count;
    logic                       init_done;

    integer          seed;
    int              errors;
    int              tests_run;
    int              tests_failed;
    int unsigned     sva_fails;
    logic [NBUF-1:0] allocated;               // buffers the testbench holds.
    read_cnt_t       exp_readers [0:NBUF-1];  // reader count given to each buffer.
    buf_ptr_t        rel_q [$];               // freed buffers in arrival order.

    em_buf_mgr em_buf_mgr_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .alloc_req          (alloc_req),
        .alloc_valid        (alloc_valid),
        .alloc_ptr          (alloc_ptr),
        .read_count_valid   (read_count_valid),
        .read_count_port_id (read_count_port_id),
        .read_count_buf_ptr (read_count_buf_ptr),
        .read_count         (read_count),
        .em_rel_buf_valid   (em_rel_buf_valid),
        .em_rel_buf_ptr     (em_rel_buf_ptr),
        .rel_buf_valid      (rel_buf_valid),
        .rel_buf_ptr        (rel_buf_ptr),
        .free_count         (free_count),
        .init_done          (init_done)
    );

    always #10 clk = ~clk;

    // Freed buffers are collected in the middle of the cycle.
    always @(negedge clk) begin
        if (rel_buf_valid === 1'b1) begin
            rel_q.push_back(rel_buf_ptr);
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
        end
    endtask

    // picks a random held buffer and drops it from the model.
    function automatic buf_ptr_t take_allocated();
        buf_ptr_t p;
        int       tries;
        p = buf_ptr_t'($random(seed));
        tries = 0;
        while (!allocated[p] && tries < NBUF) begin
            p = p + 1'b1;
            tries++;
        end
        allocated[p] = 1'b0;
        return p;
    endfunction

    task automatic alloc_one(output logic got, output buf_ptr_t ptr);
        @(posedge clk);
        alloc_req <= 1'b1;
        @(posedge clk);
        alloc_req <= 1'b0;
        @(posedge clk);
        got = alloc_valid;  // the result pulse follows one cycle after the request.
        ptr = alloc_ptr;
    endtask

    task automatic set_count(input buf_ptr_t ptr, input int n);
        @(posedge clk);
        read_count_valid   <= 1'b1;
        read_count_port_id <= port_id_t'($random(seed));
        read_count_buf_ptr <= ptr;
        read_count         <= read_cnt_t'(n);
        @(posedge clk);
        read_count_valid <= 1'b0;
        exp_readers[ptr] = read_cnt_t'(n);
    endtask

    task automatic release_burst(input buf_ptr_t ptr, input int n);
        repeat (n) begin
            @(posedge clk);
            em_rel_buf_valid <= 1'b1;
            em_rel_buf_ptr   <= ptr;
        end
        @(posedge clk);
        em_rel_buf_valid <= 1'b0;
    endtask

    // counts cycles from the last sampled release until rel_buf_valid.
    task automatic wait_release(input int limit, output int lat, output buf_ptr_t ptr);
        lat = 0;
        ptr = '0;
        while (lat < limit) begin
            @(posedge clk);
            lat++;
            if (rel_buf_valid === 1'b1) begin
                ptr = rel_buf_ptr;
                return;
            end
        end
        lat = -1;
    endtask

    task automatic wait_rel_count(input int n, input int limit);
        int waited;
        waited = 0;
        while (rel_q.size() < n && waited < limit) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic check_release(input buf_ptr_t ptr, input logic [`EM_BUF_PTR_NBITS:0] fc);
        int       lat;
        buf_ptr_t got;
        wait_release(10, lat, got);
        if (lat < 0) begin
            $display("no rel_buf_valid for buffer %h within 10 cycles", ptr);
            errors++;
        end else begin
            if (lat != 4) begin
                $display("error: rel_buf_valid latency = %0h, expected %0h", lat, 4);
                errors++;
            end
            if (got !== ptr) begin
                $display("error: rel_buf_ptr = %h, expected %h", got, ptr);
                errors++;
            end
            @(posedge clk);
            if (free_count !== fc + 5'd1) begin
                $display("error: free_count = %h, expected %h", free_count, fc + 5'd1);
                errors++;
            end
        end
        tick(4);
        if (rel_q.size() != 1) begin
            $display("buffer %h was freed %0d times instead of once", ptr, rel_q.size());
            errors++;
        end
    endtask

    task automatic reset_and_fill();
        int err0;
        int waited;
        err0 = errors;
        if (init_done !== 1'b0 || alloc_valid !== 1'b0 || rel_buf_valid !== 1'b0) begin
            $display("outputs were not low after reset");
            errors++;
        end
        waited = 0;
        while (init_done !== 1'b1 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (init_done !== 1'b1) begin
            $display("init_done did not rise within 40 cycles");
            errors++;
        end
        repeat (4) begin
            @(posedge clk);
            if (free_count !== NBUF) begin
                $display("error: free_count = %h, expected %h", free_count, NBUF);
                errors++;
            end
        end
        report_test("initialization", err0);
    endtask

    task automatic alloc_until_empty();
        int       err0;
        int       i;
        logic     got;
        buf_ptr_t p;
        err0 = errors;
        for (i = 0; i < NBUF; i++) begin
            alloc_one(got, p);
            if (got !== 1'b1) begin
                $display("allocation %0d got no alloc_valid", i);
                errors++;
            end else if (allocated[p]) begin
                $display("pointer %h was handed out twice", p);
                errors++;
            end
            if (i == 0 && p !== buf_ptr_t'(NBUF - 1)) begin
                $display("error: alloc_ptr = %h, expected %h", p, buf_ptr_t'(NBUF - 1));
                errors++;
            end
            allocated[p] = 1'b1;
            if (free_count !== NBUF - 1 - i) begin
                $display("error: free_count = %h, expected %h", free_count, NBUF - 1 - i);
                errors++;
            end
        end
        alloc_one(got, p);
        if (got !== 1'b0) begin
            $display("alloc_valid answered a request on an empty free list");
            errors++;
        end
        if (free_count !== '0) begin
            $display("error: free_count = %h, expected %h", free_count, 0);
            errors++;
        end
        report_test("allocate all buffers", err0);
    endtask

    task automatic spaced_releases();
        int                         err0;
        buf_ptr_t                   ptr;
        logic [`EM_BUF_PTR_NBITS:0] fc;
        err0 = errors;
        ptr = take_allocated();
        set_count(ptr, 1 + $unsigned($random(seed)) % 6);
        tick(4);
        fc = free_count;
        rel_q.delete();
        repeat (exp_readers[ptr] - 1) begin
            release_burst(ptr, 1);
            tick(3);
        end
        release_burst(ptr, 1);
        check_release(ptr, fc);
        report_test("spaced releases", err0);
    endtask

    task automatic back_to_back_releases();
        int                         err0;
        buf_ptr_t                   ptr;
        logic [`EM_BUF_PTR_NBITS:0] fc;
        err0 = errors;
        ptr = take_allocated();
        set_count(ptr, 2 + $unsigned($random(seed)) % 5);
        tick(4);
        fc = free_count;
        rel_q.delete();
        release_burst(ptr, exp_readers[ptr]);  // one release per cycle.
        check_release(ptr, fc);
        report_test("back-to-back releases", err0);
    endtask

    task automatic zero_count_queue();
        int                         err0;
        int                         n_c;
        buf_ptr_t                   a;
        buf_ptr_t                   b;
        buf_ptr_t                   c;
        buf_ptr_t                   others [$];
        logic [`EM_BUF_PTR_NBITS:0] fc;
        err0 = errors;
        a = take_allocated();
        b = take_allocated();
        c = take_allocated();
        set_count(c, 5);
        tick(4);
        fc = free_count;
        rel_q.delete();
        fork
            begin
                set_count(a, 0);
                set_count(b, 0);
            end
            release_burst(c, 5);  // keeps the queue waiting.
        join
        wait_rel_count(3, 40);
        tick(6);
        n_c = 0;
        foreach (rel_q[i]) begin
            if (rel_q[i] === c) begin
                n_c++;
            end else begin
                others.push_back(rel_q[i]);
            end
        end
        if (n_c != 1 || others.size() != 2 || others[0] !== a || others[1] !== b) begin
            $display("buffers %h and %h were not freed once each in order", a, b);
            errors++;
        end
        if (free_count !== fc + 5'd3) begin
            $display("error: free_count = %h, expected %h", free_count, fc + 5'd3);
            errors++;
        end
        report_test("zero read count", err0);
    endtask

    task automatic realloc_and_recount();
        int                         err0;
        logic                       got;
        buf_ptr_t                   d;
        buf_ptr_t                   p;
        logic [`EM_BUF_PTR_NBITS:0] fc;
        err0 = errors;
        d = take_allocated();
        set_count(d, 1 + $unsigned($random(seed)) % 3);
        tick(4);
        rel_q.delete();
        repeat (exp_readers[d]) begin
            release_burst(d, 1);
            tick(3);
        end
        wait_rel_count(1, 20);
        if (rel_q.size() != 1 || rel_q[0] !== d) begin
            $display("buffer %h was not freed after %0d readers", d, exp_readers[d]);
            errors++;
        end
        tick(2);
        alloc_one(got, p);  // the stack hands back the last freed pointer.
        if (got !== 1'b1) begin
            $display("reallocation got no alloc_valid");
            errors++;
        end else if (p !== d) begin
            $display("error: alloc_ptr = %h, expected %h", p, d);
            errors++;
        end
        set_count(d, 2 + $unsigned($random(seed)) % 4);
        tick(4);
        fc = free_count;
        rel_q.delete();
        repeat (exp_readers[d] - 1) begin
            release_burst(d, 1);
            tick(3);
        end
        release_burst(d, 1);
        check_release(d, fc);
        report_test("reallocation", err0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed               = 2;
        errors             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        allocated          = '0;
        clk                = 1'b0;
        rst_n              = 1'b0;
        alloc_req          = 1'b0;
        read_count_valid   = 1'b0;
        read_count_port_id = '0;
        read_count_buf_ptr = '0;
        read_count         = '0;
        em_rel_buf_valid   = 1'b0;
        em_rel_buf_ptr     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_fill();
        alloc_until_empty();
        spaced_releases();
        back_to_back_releases();
        zero_count_queue();
        realloc_and_recount();
        sva_fails = em_buf_mgr_i.buf_release_i.sva_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/em_pkg.sv
verilog/em_ram_1r1w.sv
verilog/em_sync_fifo.sv
verilog/em_buf_release.sv
verilog/em_free_list.sv
verilog/em_buf_mgr.sv
verif/em_buf_mgr_sva.sv
verif/em_buf_mgr_tb.sv

// ==== Bender.yml ====
package:
  name: em_buf_mgr

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/em_pkg.sv
      - verilog/em_ram_1r1w.sv
      - verilog/em_sync_fifo.sv
      - verilog/em_buf_release.sv
      - verilog/em_free_list.sv
      - verilog/em_buf_mgr.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/em_buf_mgr_sva.sv
      - verif/em_buf_mgr_tb.sv
